// File: hdl/soc_map_pkg.sv
//////////////////////////////////////////////////
// SoC memory map and peripheral constants
// address split, IO page register indices, timing
//////////////////////////////////////////////////
`default_nettype none

package soc_map_pkg;

  // byte address of the master port
  localparam int addr_width     = 24;
  localparam int ram_words      = 1024;
  // address bits 21..2 give the RAM word
  localparam int ram_addr_width = 20;
  localparam string ram_init_file = "firmware.hex";

  // IO page is one-hot over address bits 12..2
  localparam int io_page_bit  = 22;
  localparam int io_sel_width = 11;

  typedef enum logic [3:0] {
    io_leds        = 4'd0,
    io_ledmtx_ctrl = 4'd6,
    io_ledmtx_data = 4'd7,
    io_spi_flash   = 4'd8
  } io_reg_e;

  // LED matrix shifts on one cycle out of 2**ledmtx_div_log2
  localparam int ledmtx_div_log2 = 3;
  localparam int ledmtx_bits     = 16;
  localparam int ledmtx_cnt_w    = $clog2(ledmtx_bits + 1);

  localparam logic [7:0] flash_read_cmd = 8'h03;
  localparam int flash_addr_bits = 24;
  localparam int flash_cmd_bits  = 8 + flash_addr_bits;
  localparam int flash_snd_cnt_w = $clog2(flash_cmd_bits + 1);
  localparam int flash_data_bits = 8;
  localparam int flash_rcv_cnt_w = $clog2(flash_data_bits + 1);
  localparam int flash_busy_bit  = 8;

endpackage

`default_nettype wire

// File: hdl/soc_bus_pkg.sv
//////////////////////////////////////////////////
// SoC bus types
// master, RAM and IO requests, peripheral pins
//////////////////////////////////////////////////
`default_nettype none

package soc_bus_pkg;

  import soc_map_pkg::*;

  // request from the master, write when wmask is nonzero
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [31:0]           wdata;
    logic [3:0]            wmask;
    logic                  rstrb;
  } mem_req_t;

  typedef struct packed {
    logic [io_sel_width-1:0] sel;
    logic                    wr;
    logic                    rd;
    logic [31:0]             wdata;
  } io_req_t;

  typedef struct packed {
    logic [ram_addr_width-1:0] addr;
    logic [31:0]               wdata;
    logic [3:0]                wmask;
    logic                      en;
  } ram_req_t;

  typedef struct packed {
    logic din;
    logic cs;
    logic clk;
  } ledmtx_pins_t;

  // miso is kept out, it is the only input
  typedef struct packed {
    logic mosi;
    logic cs_n;
    logic clk;
  } spi_pins_t;

  typedef enum logic [1:0] {
    flash_idle,
    flash_send,
    flash_recv
  } flash_state_e;

endpackage

`default_nettype wire

// File: hdl/bus_decoder.sv
//////////////////////////////////////////////////
// bus decoder
// splits master requests into RAM and IO page
// requests and tracks the target of a read
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module bus_decoder
  import soc_map_pkg::*, soc_bus_pkg::*;
(
  input  wire      clk,
  input  wire      RESET,
  input  mem_req_t req,
  output ram_req_t ram_req,
  output io_req_t  io_req,
  output logic     rd_is_io
);

  logic is_io;
  logic wr;

  assign is_io = req.addr[io_page_bit];
  assign wr    = (req.wmask != 4'b0000);

  // RAM sees every read, but only writes outside the IO page
  assign ram_req.addr  = req.addr[ram_addr_width+1:2];
  assign ram_req.wdata = req.wdata;
  assign ram_req.wmask = req.wmask;
  assign ram_req.en    = req.rstrb | (wr & ~is_io);

  // one-hot register select taken from the word address bits
  assign io_req.sel   = req.addr[io_sel_width+1:2];
  assign io_req.wr    = wr & is_io;
  assign io_req.rd    = req.rstrb & is_io;
  assign io_req.wdata = req.wdata;

  // remembers where the pending read goes for the return mux
  // after reset the cleared IO word is selected, so rdata starts at zero
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      rd_is_io <= 1'b1;
    end else if (req.rstrb) begin
      rd_is_io <= is_io;
    end
  end

  // the master never mixes a read strobe with a write mask;
  // the RAM read register and the IO read word both rely on it
  a_no_read_write: assert property (
    @(posedge clk) disable iff (!RESET)
    req.rstrb |-> (req.wmask == 4'b0000)
  ) else $error("read strobe and write mask in the same cycle");

endmodule

`default_nettype wire

// File: hdl/soc_ram.sv
//////////////////////////////////////////////////
// SoC RAM
// word RAM with byte-masked writes, registered
// read and a firmware preload
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module soc_ram
  import soc_map_pkg::*, soc_bus_pkg::*;
(
  input  wire         clk,
  input  ram_req_t    ram_req,
  output logic [31:0] ram_rdata
);

  logic [31:0] mem [ram_words];
  logic [$clog2(ram_words)-1:0] idx;
  logic rd;

  // upper word address bits fold onto the populated depth
  assign idx = ram_req.addr[$clog2(ram_words)-1:0];
  assign rd  = ram_req.en && (ram_req.wmask == 4'b0000);

  initial begin
    $readmemh(ram_init_file, mem);
  end

  always_ff @(posedge clk) begin
    if (ram_req.en) begin
      for (int b = 0; b < 4; b++) begin
        if (ram_req.wmask[b]) begin
          mem[idx][8*b +: 8] <= ram_req.wdata[8*b +: 8];
        end
      end
    end
    // write cycles keep the last read word on the bus
    if (rd) begin
      ram_rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: hdl/led_matrix_tx.sv
//////////////////////////////////////////////////
// LED matrix transmitter
// shifts a 16-bit word out MSB first on a divided
// clock, with chip select low while busy
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module led_matrix_tx
  import soc_map_pkg::*, soc_bus_pkg::*;
(
  input  wire          clk,
  input  wire          RESET,
  input  io_req_t      io_req,
  output logic         busy,
  output ledmtx_pins_t pins
);

  logic [ledmtx_div_log2-1:0] div_cnt;
  logic [ledmtx_cnt_w-1:0]    bit_cnt;
  logic [ledmtx_bits-1:0]     shifter;
  logic strobe;
  logic start;

  assign strobe = (div_cnt == '0);
  assign start  = io_req.wr && io_req.sel[io_ledmtx_data];
  assign busy   = (bit_cnt != '0);

  // divider is free running, so the first strobe depends on its phase
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      if (start) begin
        bit_cnt <= ledmtx_cnt_w'(ledmtx_bits);
      end else if (busy && strobe) begin
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      shifter <= io_req.wdata[ledmtx_bits-1:0];
    end else if (busy && strobe) begin
      shifter <= {shifter[ledmtx_bits-2:0], 1'b0};
    end
  end

  // one-cycle clock pulse on each strobe, data shifts after it
  assign pins.din = busy & shifter[ledmtx_bits-1];
  assign pins.cs  = ~busy;
  assign pins.clk = busy & strobe;

endmodule

`default_nettype wire

// File: hdl/spi_flash_reader.sv
//////////////////////////////////////////////////
// SPI flash reader
// sends the read command and a 24-bit address,
// then receives one byte at half the clock rate
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module spi_flash_reader
  import soc_map_pkg::*, soc_bus_pkg::*;
(
  input  wire                        clk,
  input  wire                        RESET,
  input  io_req_t                    io_req,
  input  wire                        miso,
  output logic                       busy,
  output logic [flash_data_bits-1:0] data,
  output spi_pins_t                  pins
);

  flash_state_e state;
  logic toggle;
  logic cs_n;
  logic [flash_snd_cnt_w-1:0] snd_cnt;
  logic [flash_rcv_cnt_w-1:0] rcv_cnt;
  logic [flash_cmd_bits-1:0]  shifter;
  logic start;

  // writes while a transfer runs, or before cs_n is back up, are dropped
  assign start = io_req.wr && io_req.sel[io_spi_flash] &&
                 (state == flash_idle) && cs_n;
  assign busy  = (snd_cnt != '0) || (rcv_cnt != '0);

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      state   <= flash_idle;
      toggle  <= 1'b0;
      cs_n    <= 1'b1;
      snd_cnt <= '0;
      rcv_cnt <= '0;
    end else begin
      // restart low so the first spi clk comes after mosi settles
      toggle <= start ? 1'b0 : ~toggle;
      case (state)
        flash_idle: begin
          if (start) begin
            cs_n    <= 1'b0;
            snd_cnt <= flash_snd_cnt_w'(flash_cmd_bits);
            state   <= flash_send;
          end else if (toggle) begin
            cs_n <= 1'b1;
          end
        end
        flash_send: begin
          if (toggle) begin
            snd_cnt <= snd_cnt - 1'b1;
            if (snd_cnt == flash_snd_cnt_w'(1)) begin
              rcv_cnt <= flash_rcv_cnt_w'(flash_data_bits);
              state   <= flash_recv;
            end
          end
        end
        flash_recv: begin
          if (toggle) begin
            rcv_cnt <= rcv_cnt - 1'b1;
            if (rcv_cnt == flash_rcv_cnt_w'(1)) begin
              state <= flash_idle;
            end
          end
        end
        default: state <= flash_idle;
      endcase
    end
  end

  // command and address out, received byte in
  always_ff @(posedge clk) begin
    if (start) begin
      shifter <= {flash_read_cmd, io_req.wdata[flash_addr_bits-1:0]};
    end else if (state == flash_send && toggle) begin
      shifter <= {shifter[flash_cmd_bits-2:0], 1'b0};
    end
    if (state == flash_recv && toggle) begin
      data <= {data[flash_data_bits-2:0], miso};
    end
  end

  assign pins.mosi = (state == flash_send) & shifter[flash_cmd_bits-1];
  assign pins.cs_n = cs_n;
  assign pins.clk  = busy & toggle;

  a_clk_idle: assert property (
    @(posedge clk) disable iff (!RESET)
    pins.cs_n |-> !pins.clk
  ) else $error("spi clock toggles with cs_n high");

  a_busy_state: assert property (
    @(posedge clk) disable iff (!RESET)
    busy |-> (state != flash_idle)
  ) else $error("busy counters out of step with the FSM");

endmodule

`default_nettype wire

// File: hdl/io_regs.sv
//////////////////////////////////////////////////
// IO registers
// LED register, IO read word and the RAM/IO
// return select for the master
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module io_regs
  import soc_map_pkg::*, soc_bus_pkg::*;
(
  input  wire                        clk,
  input  wire                        RESET,
  input  io_req_t                    io_req,
  input  wire                        rd_is_io,
  input  wire [31:0]                 ram_rdata,
  input  wire                        ledmtx_busy,
  input  wire                        flash_busy,
  input  wire [flash_data_bits-1:0]  flash_data,
  output logic [3:0]                 leds,
  output logic [31:0]                rdata
);

  logic [31:0] leds_word;
  logic [31:0] ctrl_word;
  logic [31:0] flash_word;
  logic [31:0] io_word;
  logic [31:0] io_rdata_q;

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      leds <= 4'b0000;
    end else if (io_req.wr && io_req.sel[io_leds]) begin
      leds <= io_req.wdata[3:0];
    end
  end

  assign leds_word = {28'b0, leds};
  assign ctrl_word = {31'b0, ledmtx_busy};

  always_comb begin
    flash_word = '0;
    flash_word[flash_data_bits-1:0] = flash_data;
    flash_word[flash_busy_bit]      = flash_busy;
  end

  // one-hot select, so the unselected words drop out of the OR
  assign io_word = ({32{io_req.sel[io_leds]}}        & leds_word)
                 | ({32{io_req.sel[io_ledmtx_ctrl]}} & ctrl_word)
                 | ({32{io_req.sel[io_spi_flash]}}   & flash_word);

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      io_rdata_q <= '0;
    end else if (io_req.rd) begin
      io_rdata_q <= io_word;
    end
  end

  // both sources hold until the next read, so rdata does too
  assign rdata = rd_is_io ? io_rdata_q : ram_rdata;

endmodule

`default_nettype wire

// File: hdl/soc_top.sv
//////////////////////////////////////////////////
// SoC bus fabric top level
// decoder, RAM, LED matrix, SPI flash and IO regs
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module soc_top
  import soc_map_pkg::*, soc_bus_pkg::*;
(
  input  wire          clk,
  input  wire          RESET,
  input  mem_req_t     req,
  output logic [31:0]  rdata,
  output logic [3:0]   leds,
  output ledmtx_pins_t ledmtx,
  output spi_pins_t    spi,
  input  wire          spi_miso
);

  ram_req_t ram_req;
  io_req_t  io_req;
  logic     rd_is_io;
  logic [31:0] ram_rdata;
  logic ledmtx_busy;
  logic flash_busy;
  logic [flash_data_bits-1:0] flash_data;

  bus_decoder u_decoder (
    .clk      (clk),
    .RESET    (RESET),
    .req      (req),
    .ram_req  (ram_req),
    .io_req   (io_req),
    .rd_is_io (rd_is_io)
  );

  soc_ram u_ram (
    .clk       (clk),
    .ram_req   (ram_req),
    .ram_rdata (ram_rdata)
  );

  led_matrix_tx u_ledmtx (
    .clk    (clk),
    .RESET  (RESET),
    .io_req (io_req),
    .busy   (ledmtx_busy),
    .pins   (ledmtx)
  );

  spi_flash_reader u_flash (
    .clk    (clk),
    .RESET  (RESET),
    .io_req (io_req),
    .miso   (spi_miso),
    .busy   (flash_busy),
    .data   (flash_data),
    .pins   (spi)
  );

  io_regs u_io (
    .clk         (clk),
    .RESET       (RESET),
    .io_req      (io_req),
    .rd_is_io    (rd_is_io),
    .ram_rdata   (ram_rdata),
    .ledmtx_busy (ledmtx_busy),
    .flash_busy  (flash_busy),
    .flash_data  (flash_data),
    .leds        (leds),
    .rdata       (rdata)
  );

endmodule

`default_nettype wire

// File: tb/spi_flash_model.sv
//////////////////////////////////////////////////
// SPI flash model
// takes a read command and address, answers with
// one byte given by the address
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module spi_flash_model
  import soc_map_pkg::*, soc_bus_pkg::*;
(
  input  spi_pins_t                  spi,
  input  wire [flash_addr_bits-1:0]  exp_addr,
  output logic                       miso,
  output logic                       fault
);

  logic        sck;
  logic        cs_n;
  logic [31:0] frame;
  logic [7:0]  answer;
  int          n_in;
  int          n_out;

  assign sck  = spi.clk;
  assign cs_n = spi.cs_n;

  initial begin
    miso   = 1'b0;
    fault  = 1'b0;
    frame  = '0;
    answer = '0;
    n_in   = 0;
    n_out  = 0;
  end

  always @(posedge sck or negedge sck or posedge cs_n or negedge cs_n) begin
    if (cs_n) begin
      // between frames
      n_in  = 0;
      n_out = 0;
    end else if (sck) begin
      if (n_in < 32) begin
        frame = {frame[30:0], spi.mosi};
        n_in  = n_in + 1;
        if (n_in == 32) begin
          answer = frame[7:0] ^ 8'hA5;
          if (frame[31:24] !== 8'h03) begin
            $display("MISMATCH spi.mosi command got 0x%02h expected 0x03", frame[31:24]);
            fault = 1'b1;
          end
          if (frame[23:0] !== exp_addr) begin
            $display("MISMATCH spi.mosi address got 0x%06h expected 0x%06h",
                     frame[23:0], exp_addr);
            fault = 1'b1;
          end
        end
      end
    end else if (n_in == 32 && n_out < 8) begin
      // answer msb first, changing while spi clk is low
      miso  = answer[7 - n_out];
      n_out = n_out + 1;
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_soc.sv
//////////////////////////////////////////////////
// SoC bus fabric testbench
// table of RAM, LED, LED matrix and SPI flash
// operations applied on the master port
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module tb_soc
  import soc_map_pkg::*, soc_bus_pkg::*;
();

  typedef enum logic [2:0] {
    op_wr_ram,
    op_rd_ram,
    op_wr_led,
    op_rd_led,
    op_matrix,
    op_flash
  } op_e;

  typedef struct packed {
    op_e                   op;
    logic [addr_width-1:0] addr;
    logic [31:0]           data;
    logic [3:0]            mask;
    logic [31:0]           exp;
  } step_t;

  localparam int n_ops   = 24;
  localparam int n_words = 4;

  logic         clk;
  logic         RESET;
  mem_req_t     req;
  logic [31:0]  rdata;
  logic [3:0]   leds;
  ledmtx_pins_t ledmtx;
  spi_pins_t    spi;
  logic         spi_miso;
  logic         flash_fault;
  logic [flash_addr_bits-1:0] flash_addr_exp;

  step_t       steps [n_ops];
  int          n_steps;
  logic [31:0] ram_model [n_words];
  int          seed;

  soc_top u_dut (
    .clk      (clk),
    .RESET    (RESET),
    .req      (req),
    .rdata    (rdata),
    .leds     (leds),
    .ledmtx   (ledmtx),
    .spi      (spi),
    .spi_miso (spi_miso)
  );

  spi_flash_model u_flash_model (
    .spi      (spi),
    .exp_addr (flash_addr_exp),
    .miso     (spi_miso),
    .fault    (flash_fault)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_matrix(input string name, input logic [ledmtx_bits-1:0] got,
                              input logic [ledmtx_bits-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%04h expected 0x%04h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [flash_data_bits-1:0] got,
                            input logic [flash_data_bits-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp);
      stop_run();
    end
  endtask

  // IO page bit plus the one-hot register bit above the byte offset
  function automatic logic [addr_width-1:0] io_addr(input io_reg_e r);
    logic [addr_width-1:0] a;
    a = '0;
    a[io_page_bit] = 1'b1;
    a[int'(r) + 2] = 1'b1;
    return a;
  endfunction

  function automatic logic [addr_width-1:0] ram_addr(input int slot);
    return addr_width'((slot * 97 + 5) * 4);
  endfunction

  task automatic add_step(input op_e op, input logic [addr_width-1:0] addr,
                          input logic [31:0] data, input logic [3:0] mask,
                          input logic [31:0] exp);
    steps[n_steps] = '{op, addr, data, mask, exp};
    n_steps++;
  endtask

  task automatic build_table();
    int i;
    int b;
    logic [31:0] d;
    logic [3:0]  m;
    logic [3:0]  led_val;
    n_steps = 0;
    led_val = 4'h0;
    add_step(op_rd_led, io_addr(io_leds), 32'h0, 4'h0, 32'h0);
    // a full write sets each model word, a masked write then patches it
    for (i = 0; i < n_words; i++) begin
      d = $random(seed);
      ram_model[i] = d;
      add_step(op_wr_ram, ram_addr(i), d, 4'hf, 32'h0);
      d = $random(seed);
      m = 4'($random(seed));
      for (b = 0; b < 4; b++) begin
        if (m[b]) begin
          ram_model[i][8*b +: 8] = d[8*b +: 8];
        end
      end
      add_step(op_wr_ram, ram_addr(i), d, m, 32'h0);
    end
    // back to back, the last written word first
    for (i = n_words - 1; i >= 0; i--) begin
      add_step(op_rd_ram, ram_addr(i), 32'h0, 4'h0, ram_model[i]);
    end
    for (i = 0; i < 2; i++) begin
      d = $random(seed);
      led_val = d[3:0];
      add_step(op_wr_led, io_addr(io_leds), d, 4'hf, {28'b0, led_val});
      add_step(op_rd_led, io_addr(io_leds), 32'h0, 4'h0, {28'b0, led_val});
    end
    for (i = 0; i < 2; i++) begin
      d = $random(seed);
      add_step(op_matrix, io_addr(io_ledmtx_data), d, 4'hf, {16'b0, d[15:0]});
    end
    for (i = 0; i < 2; i++) begin
      d = {8'h00, 24'($random(seed))};
      add_step(op_flash, io_addr(io_spi_flash), d, 4'hf, {24'b0, d[7:0] ^ 8'hA5});
    end
    add_step(op_rd_ram, ram_addr(0), 32'h0, 4'h0, ram_model[0]);
    add_step(op_rd_led, io_addr(io_leds), 32'h0, 4'h0, {28'b0, led_val});
    add_step(op_rd_ram, ram_addr(1), 32'h0, 4'h0, ram_model[1]);
  endtask

  // drive one request cycle, return at the next falling edge with the bus idle
  task automatic issue(input logic [addr_width-1:0] addr, input logic [31:0] data,
                       input logic [3:0] mask, input logic rstrb);
    req.addr  = addr;
    req.wdata = data;
    req.wmask = mask;
    req.rstrb = rstrb;
    @(negedge clk);
    req = '0;
  endtask

  task automatic send_matrix(input step_t s);
    logic [ledmtx_bits-1:0] captured;
    int n_bits;
    captured = '0;
    n_bits = 0;
    issue(s.addr, s.data, s.mask, 1'b0);
    check_bit("ledmtx.cs", ledmtx.cs, 1'b0);
    while (!ledmtx.cs) begin
      if (ledmtx.clk) begin
        captured = {captured[ledmtx_bits-2:0], ledmtx.din};
        n_bits++;
      end
      issue(io_addr(io_ledmtx_ctrl), 32'h0, 4'h0, 1'b1);
      check_word("rdata", rdata, 32'h1);
    end
    if (n_bits != ledmtx_bits) begin
      $display("LED matrix gave %0d clock pulses instead of %0d", n_bits, ledmtx_bits);
      stop_run();
    end
    check_matrix("ledmtx.din", captured, s.exp[ledmtx_bits-1:0]);
    issue(io_addr(io_ledmtx_ctrl), 32'h0, 4'h0, 1'b1);
    check_word("rdata", rdata, 32'h0);
  endtask

  task automatic flash_read(input step_t s);
    logic [31:0] word;
    int waits;
    flash_addr_exp = s.data[flash_addr_bits-1:0];
    issue(s.addr, s.data, s.mask, 1'b0);
    check_bit("spi.cs_n", spi.cs_n, 1'b0);
    word = 32'h0;
    word[flash_busy_bit] = 1'b1;
    while (word[flash_busy_bit]) begin
      issue(s.addr, 32'h0, 4'h0, 1'b1);
      word = rdata;
    end
    check_byte("rdata[7:0]", word[7:0], s.exp[7:0]);
    check_word("rdata", word, s.exp);
    // cs_n rises on the next toggle-high cycle
    waits = 0;
    while (!spi.cs_n && waits < 4) begin
      @(negedge clk);
      waits++;
    end
    check_bit("spi.cs_n", spi.cs_n, 1'b1);
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      op_wr_ram: issue(s.addr, s.data, s.mask, 1'b0);
      op_wr_led: begin
        issue(s.addr, s.data, s.mask, 1'b0);
        check_word("leds", {28'b0, leds}, s.exp);
      end
      op_rd_ram, op_rd_led: begin
        issue(s.addr, 32'h0, 4'h0, 1'b1);
        check_word("rdata", rdata, s.exp);
      end
      op_matrix: send_matrix(s);
      op_flash:  flash_read(s);
      default: begin
        $display("stimulus table holds an unknown operation");
        stop_run();
      end
    endcase
  endtask

  always @(posedge flash_fault) begin
    $display("flash model received a wrong read command or address");
    stop_run();
  end

  initial begin
    #(n_ops * 2000);
    $display("run timed out before the stimulus table was done");
    stop_run();
  end

  initial begin
    int i;
    seed = 32'h5655;
    RESET = 1'b0;
    req = '0;
    flash_addr_exp = '0;
    build_table();
    repeat (5) @(negedge clk);
    RESET = 1'b1;
    check_word("leds", {28'b0, leds}, 32'h0);
    check_word("rdata", rdata, 32'h0);
    check_bit("ledmtx.cs", ledmtx.cs, 1'b1);
    check_bit("ledmtx.clk", ledmtx.clk, 1'b0);
    check_bit("spi.cs_n", spi.cs_n, 1'b1);
    check_bit("spi.clk", spi.clk, 1'b0);
    for (i = 0; i < n_ops; i++) begin
      run_step(steps[i]);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hdl/soc_map_pkg.sv
hdl/soc_bus_pkg.sv
hdl/bus_decoder.sv
hdl/soc_ram.sv
hdl/led_matrix_tx.sv
hdl/spi_flash_reader.sv
hdl/io_regs.sv
hdl/soc_top.sv
tb/spi_flash_model.sv
tb/tb_soc.sv

// File: Makefile
# Verilator build and run of the SoC bus fabric testbench
BIN  := obj_dir/Vtb_soc
SRCS := $(wildcard hdl/*.sv tb/*.sv)

.PHONY: all run clean

all: run

$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f sim.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: firmware.hex
// one 32-bit RAM word per line, in hex, from word 0 upwards
00000013
00000013
00000013
0000006f
